// File: Bender.yml
package:
  name: soc_bus

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/soc_bus_pkg.sv
      - rtl/periph_if.sv
      - rtl/bus_decoder.sv
      - rtl/sram_ctrl.sv
      - rtl/boot_rom.sv
      - rtl/uart.sv
      - rtl/digseg_driver.sv
      - rtl/soc_bus_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_soc_bus.sv

// File: rtl/boot_rom.sv
`default_nettype none

`include "soc_bus_config.svh"

module boot_rom (
	input wire logic clk,
	input wire logic reset_i,
	periph_if.dev    dev
);
	import soc_bus_pkg::*;

	word_t                  rdata_q;
	logic [`SOC_ROM_AW-1:0] idx;
	logic                   in_range;

	// Boot word n
	function automatic word_t rom_word(input logic [`SOC_ROM_AW-1:0] n);
		word_t prod;
		prod = word_t'(n) * 32'h0101_0101;
		return prod ^ 32'hB007_0000;
	endfunction

	assign idx      = dev.addr[`SOC_ROM_AW-1:0];
	assign in_range = (dev.addr[31:`SOC_ROM_AW] == '0);

	always_ff @(posedge clk) begin
		rdata_q <= in_range ? rom_word(idx) : '0;
	end

	assign dev.rdata = rdata_q;
	assign dev.ack   = dev.req;

	// Decoder answers ROM writes itself
	no_write_req: assert property (
		@(posedge clk) disable iff (reset_i) dev.req |-> !dev.we
	);

endmodule

`default_nettype wire

// File: rtl/bus_decoder.sv
`default_nettype none

module bus_decoder (
	input  wire logic                  clk,
	input  wire logic                  reset_i,
	input  wire logic                  wb_stb_i,
	input  wire logic                  wb_cyc_i,
	input  wire logic                  wb_we_i,
	input  wire soc_bus_pkg::dev_sel_e wb_sel_i,
	input  wire soc_bus_pkg::word_t    wb_addr_i,
	input  wire soc_bus_pkg::word_t    wb_data_i,
	output soc_bus_pkg::word_t         wb_data_o,
	output logic                       wb_ack_o,
	periph_if.bus                      ram_bus,
	periph_if.bus                      rom_bus,
	periph_if.bus                      uart_bus,
	periph_if.bus                      seg_bus,
	input  wire logic [1:0]            uart_status_i
);
	import soc_bus_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_DONE} state_e;

	state_e   state_q;
	dev_sel_e sel_q;
	logic     req_q;
	logic     start;
	logic     local_hit;
	word_t    local_data;
	logic     dev_ack;
	word_t    dev_rdata;

	assign start = (state_q == ST_IDLE) && wb_stb_i && wb_cyc_i;

	// Codes answered without a device
	always_comb begin
		case (wb_sel_i)
			RAM, UART, DIGSEG: local_hit = 1'b0;
			ROM:               local_hit = wb_we_i;
			default:           local_hit = 1'b1;
		endcase
	end

	// Status bit 0 is tx busy, bit 1 is rx ready
	assign local_data = (wb_sel_i == UART_STAT) ? {30'b0, uart_status_i} : '0;

	// Master holds these stable until ack
	assign ram_bus.we     = wb_we_i;
	assign ram_bus.addr   = wb_addr_i;
	assign ram_bus.wdata  = wb_data_i;
	assign rom_bus.we     = wb_we_i;
	assign rom_bus.addr   = wb_addr_i;
	assign rom_bus.wdata  = wb_data_i;
	assign uart_bus.we    = wb_we_i;
	assign uart_bus.addr  = wb_addr_i;
	assign uart_bus.wdata = wb_data_i;
	assign seg_bus.we     = wb_we_i;
	assign seg_bus.addr   = wb_addr_i;
	assign seg_bus.wdata  = wb_data_i;

	assign ram_bus.req  = req_q && (sel_q == RAM);
	assign rom_bus.req  = req_q && (sel_q == ROM);
	assign uart_bus.req = req_q && (sel_q == UART);
	assign seg_bus.req  = req_q && (sel_q == DIGSEG);

	always_comb begin
		dev_ack   = 1'b0;
		dev_rdata = '0;
		case (sel_q)
			RAM: begin
				dev_ack   = ram_bus.ack;
				dev_rdata = ram_bus.rdata;
			end
			ROM: begin
				dev_ack   = rom_bus.ack;
				dev_rdata = rom_bus.rdata;
			end
			UART: begin
				dev_ack   = uart_bus.ack;
				dev_rdata = uart_bus.rdata;
			end
			DIGSEG: begin
				dev_ack   = seg_bus.ack;
				dev_rdata = seg_bus.rdata;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q  <= ST_IDLE;
			sel_q    <= ZERO;
			req_q    <= 1'b0;
			wb_ack_o <= 1'b0;
		end else begin
			req_q    <= 1'b0;
			wb_ack_o <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (start) begin
						sel_q <= wb_sel_i;
						if (local_hit) begin
							wb_ack_o <= 1'b1;
							state_q  <= ST_DONE;
						end else begin
							req_q   <= 1'b1;
							state_q <= ST_WAIT;
						end
					end
				end
				ST_WAIT: begin
					if (dev_ack) begin
						wb_ack_o <= 1'b1;
						state_q  <= ST_DONE;
					end
				end
				// Stb still high here, skip it
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start && local_hit) begin
			wb_data_o <= local_data;
		end else if (state_q == ST_WAIT && dev_ack) begin
			wb_data_o <= dev_rdata;
		end
	end

	ack_single_cycle: assert property (
		@(posedge clk) disable iff (reset_i) wb_ack_o |=> !wb_ack_o
	);

	// One request per transfer, raised only on leaving idle
	req_one_device: assert property (
		@(posedge clk) disable iff (reset_i)
		(ram_bus.req || rom_bus.req || uart_bus.req || seg_bus.req) |->
			state_q == ST_WAIT && $past(state_q) == ST_IDLE
	);

endmodule

`default_nettype wire

// File: rtl/digseg_driver.sv
`default_nettype none

module digseg_driver (
	input  wire logic clk,
	input  wire logic reset_i,
	periph_if.dev     dev,
	output logic [6:0] seg1_o,
	output logic [6:0] seg0_o
);

	logic [3:0] dig1_q;
	logic [3:0] dig0_q;

	// Segment a in bit 6, g in bit 0
	function automatic logic [6:0] hex_to_seg(input logic [3:0] d);
		logic [6:0] seg;
		case (d)
			4'h0: seg = 7'h7E;
			4'h1: seg = 7'h30;
			4'h2: seg = 7'h6D;
			4'h3: seg = 7'h79;
			4'h4: seg = 7'h33;
			4'h5: seg = 7'h5B;
			4'h6: seg = 7'h5F;
			4'h7: seg = 7'h70;
			4'h8: seg = 7'h7F;
			4'h9: seg = 7'h7B;
			4'hA: seg = 7'h77;
			4'hB: seg = 7'h1F;
			4'hC: seg = 7'h4E;
			4'hD: seg = 7'h3D;
			4'hE: seg = 7'h4F;
			default: seg = 7'h47;
		endcase
		return seg;
	endfunction

	always_ff @(posedge clk) begin
		if (reset_i) begin
			dig1_q <= '0;
			dig0_q <= '0;
		end else if (dev.req && dev.we) begin
			dig1_q <= dev.wdata[7:4];
			dig0_q <= dev.wdata[3:0];
		end
	end

	assign dev.rdata = {24'b0, dig1_q, dig0_q};
	assign dev.ack   = dev.req;

	assign seg1_o = hex_to_seg(dig1_q);
	assign seg0_o = hex_to_seg(dig0_q);

endmodule

`default_nettype wire

// File: rtl/periph_if.sv
`default_nettype none

interface periph_if;
	import soc_bus_pkg::*;

	// Single-cycle request strobe
	logic  req;
	logic  we;
	word_t addr;
	word_t wdata;
	// Valid in the ack cycle
	word_t rdata;
	logic  ack;

	modport bus (
		output req, we, addr, wdata,
		input  rdata, ack
	);

	modport dev (
		input  req, we, addr, wdata,
		output rdata, ack
	);

endinterface

`default_nettype wire

// File: rtl/soc_bus_config.svh
`ifndef SOC_BUS_CONFIG_SVH
`define SOC_BUS_CONFIG_SVH

// On-chip RAM depth, as address width in words
`define SOC_RAM_AW 10

// Boot ROM depth, as address width in words
`define SOC_ROM_AW 4

// Serial bit time in clock cycles
`define SOC_UART_CLKS_PER_BIT 16

// Width of the device select code
`define SOC_SEL_W 4

`endif

// File: rtl/soc_bus_pkg.sv
`default_nettype none

`include "soc_bus_config.svh"

package soc_bus_pkg;

	// Device select codes on the master port
	typedef enum logic [`SOC_SEL_W-1:0] {
		ZERO      = 0,
		RAM       = 1,
		ROM       = 2,
		FLASH     = 3,
		VGA       = 4,
		UART      = 5,
		UART_STAT = 6,
		DIGSEG    = 7,
		PS2       = 8
	} dev_sel_e;

	// Address, write data and read data word
	typedef logic [31:0] word_t;

endpackage

`default_nettype wire

// File: rtl/soc_bus_top.sv
`default_nettype none

module soc_bus_top (
	input  wire logic                  clk,
	input  wire logic                  reset_i,
	input  wire logic                  wb_stb_i,
	input  wire logic                  wb_cyc_i,
	input  wire logic                  wb_we_i,
	input  wire soc_bus_pkg::dev_sel_e wb_sel_i,
	input  wire soc_bus_pkg::word_t    wb_addr_i,
	input  wire soc_bus_pkg::word_t    wb_data_i,
	output soc_bus_pkg::word_t         wb_data_o,
	output logic                       wb_ack_o,
	output logic                       uart_txd_o,
	input  wire logic                  uart_rxd_i,
	output logic                       uart_tx_busy_o,
	output logic                       uart_rx_ready_o,
	output logic [6:0]                 seg1_o,
	output logic [6:0]                 seg0_o
);

	periph_if ram_if ();
	periph_if rom_if ();
	periph_if uart_if ();
	periph_if seg_if ();

	bus_decoder decoder_i (
		.clk           (clk),
		.reset_i       (reset_i),
		.wb_stb_i      (wb_stb_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_we_i       (wb_we_i),
		.wb_sel_i      (wb_sel_i),
		.wb_addr_i     (wb_addr_i),
		.wb_data_i     (wb_data_i),
		.wb_data_o     (wb_data_o),
		.wb_ack_o      (wb_ack_o),
		.ram_bus       (ram_if.bus),
		.rom_bus       (rom_if.bus),
		.uart_bus      (uart_if.bus),
		.seg_bus       (seg_if.bus),
		.uart_status_i ({uart_rx_ready_o, uart_tx_busy_o})
	);

	sram_ctrl sram_i (
		.clk     (clk),
		.reset_i (reset_i),
		.dev     (ram_if.dev)
	);

	boot_rom rom_i (
		.clk     (clk),
		.reset_i (reset_i),
		.dev     (rom_if.dev)
	);

	uart uart_i (
		.clk        (clk),
		.reset_i    (reset_i),
		.dev        (uart_if.dev),
		.tx_busy_o  (uart_tx_busy_o),
		.rx_ready_o (uart_rx_ready_o),
		.txd_o      (uart_txd_o),
		.rxd_i      (uart_rxd_i)
	);

	digseg_driver digseg_i (
		.clk     (clk),
		.reset_i (reset_i),
		.dev     (seg_if.dev),
		.seg1_o  (seg1_o),
		.seg0_o  (seg0_o)
	);

endmodule

`default_nettype wire

// File: rtl/sram_ctrl.sv
`default_nettype none

`include "soc_bus_config.svh"

module sram_ctrl (
	input wire logic clk,
	input wire logic reset_i,
	periph_if.dev    dev
);
	import soc_bus_pkg::*;

	localparam int Depth = 1 << `SOC_RAM_AW;

	word_t                  mem [Depth];
	word_t                  rdata_q;
	logic [`SOC_RAM_AW-1:0] idx;

	assign idx = dev.addr[`SOC_RAM_AW-1:0];

	// Read port follows the address every cycle
	always_ff @(posedge clk) begin
		if (dev.req && dev.we) begin
			mem[idx] <= dev.wdata;
		end
		rdata_q <= mem[idx];
	end

	assign dev.rdata = rdata_q;
	assign dev.ack   = dev.req;

	// Acked at once, so the decoder must idle before the next request
	req_no_repeat: assert property (
		@(posedge clk) disable iff (reset_i) dev.req |=> !dev.req
	);

endmodule

`default_nettype wire

// File: rtl/uart.sv
`default_nettype none

`include "soc_bus_config.svh"

module uart (
	input  wire logic clk,
	input  wire logic reset_i,
	periph_if.dev     dev,
	output logic      tx_busy_o,
	output logic      rx_ready_o,
	output logic      txd_o,
	input  wire logic rxd_i
);
	import soc_bus_pkg::*;

	localparam int ClksPerBit = `SOC_UART_CLKS_PER_BIT;
	localparam int CntW       = $clog2(ClksPerBit);

	logic [CntW-1:0] tx_cnt;
	logic [3:0]      tx_bit;
	logic [8:0]      tx_shift;
	logic [7:0]      wr_byte;
	logic            wr_pend;
	logic            tx_go;

	logic [1:0]      rx_sync;
	logic            rx_active;
	logic [CntW-1:0] rx_cnt;
	logic [3:0]      rx_bit;
	logic [7:0]      rx_shift;
	logic [7:0]      rx_byte;
	logic            rd_pend;
	logic            rd_go;

	logic            ack_q;
	word_t           rdata_q;

	assign tx_go = wr_pend && !tx_busy_o;
	assign rd_go = rd_pend && rx_ready_o;

	// Transmitter, 8N1
	always_ff @(posedge clk) begin
		if (reset_i) begin
			tx_busy_o <= 1'b0;
			txd_o     <= 1'b1;
			tx_cnt    <= '0;
			tx_bit    <= '0;
			wr_pend   <= 1'b0;
		end else if (tx_go) begin
			tx_busy_o <= 1'b1;
			txd_o     <= 1'b0;
			tx_shift  <= {1'b1, wr_byte};
			tx_cnt    <= '0;
			tx_bit    <= '0;
			wr_pend   <= 1'b0;
		end else begin
			if (dev.req && dev.we) begin
				wr_pend <= 1'b1;
				wr_byte <= dev.wdata[7:0];
			end
			if (tx_busy_o) begin
				tx_cnt <= tx_cnt + 1'b1;
				if (tx_cnt == CntW'(ClksPerBit - 1)) begin
					tx_cnt <= '0;
					if (tx_bit == 4'd9) begin
						tx_busy_o <= 1'b0;
					end else begin
						txd_o    <= tx_shift[0];
						tx_shift <= {1'b1, tx_shift[8:1]};
						tx_bit   <= tx_bit + 1'b1;
					end
				end
			end
		end
	end

	// Receiver, sampled mid-bit
	always_ff @(posedge clk) begin
		if (reset_i) begin
			rx_sync    <= 2'b11;
			rx_active  <= 1'b0;
			rx_cnt     <= '0;
			rx_bit     <= '0;
			rx_ready_o <= 1'b0;
			rd_pend    <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rxd_i};
			if (dev.req && !dev.we) begin
				rd_pend <= 1'b1;
			end
			if (rd_go) begin
				rd_pend    <= 1'b0;
				rx_ready_o <= 1'b0;
			end
			if (!rx_active) begin
				if (!rx_sync[1]) begin
					rx_active <= 1'b1;
					rx_cnt    <= '0;
					rx_bit    <= '0;
				end
			end else begin
				rx_cnt <= rx_cnt + 1'b1;
				if (rx_cnt == CntW'(ClksPerBit / 2 - 1)) begin
					if (rx_bit == 4'd0 && rx_sync[1]) begin
						rx_active <= 1'b0;
					end else if (rx_bit == 4'd9) begin
						// Stop bit reached, free for the next start edge
						rx_active  <= 1'b0;
						rx_byte    <= rx_shift;
						rx_ready_o <= 1'b1;
					end else if (rx_bit != 4'd0) begin
						rx_shift <= {rx_sync[1], rx_shift[7:1]};
					end
				end
				if (rx_cnt == CntW'(ClksPerBit - 1)) begin
					rx_cnt <= '0;
					rx_bit <= rx_bit + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= tx_go || rd_go;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_go) begin
			rdata_q <= {24'b0, rx_byte};
		end
	end

	assign dev.ack   = ack_q;
	assign dev.rdata = rdata_q;

	line_idle_high: assert property (
		@(posedge clk) disable iff (reset_i) !tx_busy_o |-> txd_o
	);

endmodule

`default_nettype wire

// File: tb.f
+incdir+rtl
rtl/soc_bus_pkg.sv
rtl/periph_if.sv
rtl/bus_decoder.sv
rtl/sram_ctrl.sv
rtl/boot_rom.sv
rtl/uart.sv
rtl/digseg_driver.sv
rtl/soc_bus_top.sv
tests/tb_soc_bus.sv

// File: tests/tb_soc_bus.sv
`default_nettype none

`include "soc_bus_config.svh"

module tb_soc_bus;
	import soc_bus_pkg::*;

	localparam int RamWords  = 1 << `SOC_RAM_AW;
	localparam int RomWords  = 1 << `SOC_ROM_AW;
	localparam int NumRam    = 12;
	localparam int NumXfer   = 70;
	localparam int NumFrames = 2;
	// A frame can wait behind the one before it
	localparam int Limit = 60 + NumXfer * 6 + NumFrames * 2 * 10 * `SOC_UART_CLKS_PER_BIT;

	// Seven-segment patterns, digit F in the top slot, a in bit 6
	localparam logic [16*7-1:0] SegTable = {
		7'h47, 7'h4F, 7'h3D, 7'h4E, 7'h1F, 7'h77, 7'h7B, 7'h7F,
		7'h70, 7'h5F, 7'h5B, 7'h33, 7'h79, 7'h6D, 7'h30, 7'h7E
	};

	logic       clk;
	logic       reset_i;
	logic       wb_stb_i;
	logic       wb_cyc_i;
	logic       wb_we_i;
	dev_sel_e   wb_sel_i;
	word_t      wb_addr_i;
	word_t      wb_data_i;
	word_t      wb_data_o;
	logic       wb_ack_o;
	logic       uart_txd_o;
	logic       uart_tx_busy_o;
	logic       uart_rx_ready_o;
	logic [6:0] seg1_o;
	logic [6:0] seg0_o;

	word_t       shadow_ram [RamWords];
	logic [7:0]  shadow_seg;
	logic [7:0]  shadow_rx;
	logic [31:0] lfsr_state;
	word_t       ram_addr [NumRam];
	int          order [NumRam];

	word_t exp_data;
	logic  exp_check;
	int    exp_lat;
	logic  pending;
	int    wait_cycles;
	logic  ack_prev;
	int    err_data;
	int    err_timing;
	int    err_other;
	int    cycles;

	soc_bus_top dut_i (
		.clk             (clk),
		.reset_i         (reset_i),
		.wb_stb_i        (wb_stb_i),
		.wb_cyc_i        (wb_cyc_i),
		.wb_we_i         (wb_we_i),
		.wb_sel_i        (wb_sel_i),
		.wb_addr_i       (wb_addr_i),
		.wb_data_i       (wb_data_i),
		.wb_data_o       (wb_data_o),
		.wb_ack_o        (wb_ack_o),
		.uart_txd_o      (uart_txd_o),
		.uart_rxd_i      (uart_txd_o),
		.uart_tx_busy_o  (uart_tx_busy_o),
		.uart_rx_ready_o (uart_rx_ready_o),
		.seg1_o          (seg1_o),
		.seg0_o          (seg0_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic word_t take_bits(input int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [6:0] seg_pattern(input logic [3:0] d);
		return SegTable[d*7 +: 7];
	endfunction

	// Expected read data for one transfer
	function automatic word_t expected_data(input dev_sel_e sel, input logic we,
			input word_t addr, input logic [1:0] status);
		if (sel == UART_STAT) begin
			return {30'b0, status};
		end
		if (we) begin
			return '0;
		end
		case (sel)
			RAM:     return shadow_ram[addr[`SOC_RAM_AW-1:0]];
			ROM:     return (addr < RomWords) ? (addr * 32'h0101_0101) ^ 32'hB007_0000 : '0;
			UART:    return {24'b0, shadow_rx};
			DIGSEG:  return {24'b0, shadow_seg};
			default: return '0;
		endcase
	endfunction

	// Cycles from sampling to ack, zero where the latency varies
	function automatic int ack_latency(input dev_sel_e sel, input logic we);
		case (sel)
			RAM, DIGSEG: return 2;
			ROM:         return we ? 1 : 2;
			UART:        return 0;
			default:     return 1;
		endcase
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t want);
		assert (got === want) else begin
			err_data++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic bus_xfer(input dev_sel_e sel, input logic we, input word_t addr,
			input word_t data);
		@(posedge clk);
		#1;
		exp_data    = expected_data(sel, we, addr, {uart_rx_ready_o, uart_tx_busy_o});
		exp_lat     = ack_latency(sel, we);
		exp_check   = !we || exp_lat == 1;
		wait_cycles = 0;
		pending     = 1'b1;
		wb_stb_i    = 1'b1;
		wb_cyc_i    = 1'b1;
		wb_we_i     = we;
		wb_sel_i    = sel;
		wb_addr_i   = addr;
		wb_data_i   = data;
		do begin
			@(negedge clk);
		end while (!wb_ack_o);
		@(posedge clk);
		#1;
		wb_stb_i = 1'b0;
		wb_cyc_i = 1'b0;
		if (we && sel == RAM) begin
			shadow_ram[addr[`SOC_RAM_AW-1:0]] = data;
		end else if (we && sel == DIGSEG) begin
			shadow_seg = data[7:0];
		end else if (we && sel == UART) begin
			shadow_rx = data[7:0];
		end
	endtask

	always @(negedge clk) begin
		assert (!(wb_ack_o && ack_prev)) else begin
			err_timing++;
			$display("Acknowledge held for more than one cycle at %0t", $time);
		end
		assert (!wb_ack_o || pending) else begin
			err_other++;
			$display("Acknowledge without an open request at %0t", $time);
		end
		if (pending) begin
			wait_cycles++;
			if (wb_ack_o) begin
				pending = 1'b0;
				if (exp_check) begin
					assert (wb_data_o === exp_data) else begin
						err_data++;
						$display("Fail at %0t: wb_data_o is %h, expected %h",
							$time, wb_data_o, exp_data);
					end
				end
				if (exp_lat != 0) begin
					assert (wait_cycles - 1 == exp_lat) else begin
						err_timing++;
						$display("Fail at %0t: wb_ack_o latency is %0d, expected %0d",
							$time, wait_cycles - 1, exp_lat);
					end
				end
			end
		end
		ack_prev = wb_ack_o;
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > Limit) begin
				$display("Timeout after %0d cycles, a transfer never completed", cycles);
				$display("Testbench failed");
				$finish;
			end
		end
	end

	initial begin
		word_t      rnd;
		logic [7:0] tx_byte;
		logic [7:0] seg_byte;
		int         j;
		int         tmp;
		dev_sel_e   unmapped [4];

		lfsr_state = 32'hccf10d1a;
		reset_i    = 1'b1;
		wb_stb_i   = 1'b0;
		wb_cyc_i   = 1'b0;
		wb_we_i    = 1'b0;
		wb_sel_i   = ZERO;
		wb_addr_i  = '0;
		wb_data_i  = '0;
		pending    = 1'b0;
		ack_prev   = 1'b0;
		err_data   = 0;
		err_timing = 0;
		err_other  = 0;
		shadow_seg = '0;
		shadow_rx  = '0;
		unmapped[0] = ZERO;
		unmapped[1] = FLASH;
		unmapped[2] = VGA;
		unmapped[3] = PS2;
		repeat (4) @(posedge clk);
		#1;
		reset_i = 1'b0;

		@(negedge clk);
		check_value("wb_ack_o", wb_ack_o, 0);
		check_value("uart_tx_busy_o", uart_tx_busy_o, 0);
		check_value("uart_rx_ready_o", uart_rx_ready_o, 0);
		check_value("uart_txd_o", uart_txd_o, 1);

		for (int i = 0; i < NumRam; i++) begin
			ram_addr[i] = take_bits(32);
			order[i]    = i;
			bus_xfer(RAM, 1'b1, ram_addr[i], take_bits(32));
		end
		// Shuffle the read order
		for (int i = NumRam - 1; i > 0; i--) begin
			j        = take_bits(8) % (i + 1);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < NumRam; i++) begin
			bus_xfer(RAM, 1'b0, ram_addr[order[i]], '0);
		end

		for (int n = 0; n < RomWords + 2; n++) begin
			bus_xfer(ROM, 1'b0, n, '0);
		end
		bus_xfer(ROM, 1'b0, 32'h0000_0100, '0);
		bus_xfer(ROM, 1'b1, 32'd3, take_bits(32));
		bus_xfer(ROM, 1'b0, 32'd3, '0);

		repeat (3) begin
			rnd      = take_bits(8);
			seg_byte = rnd[7:0];
			bus_xfer(DIGSEG, 1'b1, '0, {24'b0, seg_byte});
			check_value("seg1_o", seg1_o, seg_pattern(seg_byte[7:4]));
			check_value("seg0_o", seg0_o, seg_pattern(seg_byte[3:0]));
			bus_xfer(DIGSEG, 1'b0, '0, '0);
		end

		// First frame, read once it has arrived
		rnd     = take_bits(8);
		tx_byte = rnd[7:0];
		bus_xfer(UART, 1'b1, '0, {24'b0, tx_byte});
		check_value("uart_tx_busy_o", uart_tx_busy_o, 1);
		while (!uart_rx_ready_o) @(negedge clk);
		bus_xfer(UART_STAT, 1'b0, '0, '0);
		bus_xfer(UART, 1'b0, '0, '0);
		check_value("uart_rx_ready_o", uart_rx_ready_o, 0);

		// Second frame, read waits for it inside the UART
		rnd     = take_bits(8);
		tx_byte = rnd[7:0];
		bus_xfer(UART, 1'b1, '0, {24'b0, tx_byte});
		bus_xfer(UART_STAT, 1'b0, '0, '0);
		bus_xfer(UART, 1'b0, '0, '0);
		check_value("uart_rx_ready_o", uart_rx_ready_o, 0);
		while (uart_tx_busy_o) @(negedge clk);
		bus_xfer(UART_STAT, 1'b0, '0, '0);

		// Writes aim at a live RAM word, which must survive them
		foreach (unmapped[k]) begin
			bus_xfer(unmapped[k], 1'b1, ram_addr[order[0]], take_bits(32));
			bus_xfer(unmapped[k], 1'b0, take_bits(32), '0);
		end
		bus_xfer(RAM, 1'b0, ram_addr[order[0]], '0);
		bus_xfer(DIGSEG, 1'b0, '0, '0);
		check_value("seg1_o", seg1_o, seg_pattern(shadow_seg[7:4]));
		check_value("seg0_o", seg0_o, seg_pattern(shadow_seg[3:0]));

		$display("Errors: %0d data, %0d timing, %0d other", err_data, err_timing, err_other);
		if (err_data + err_timing + err_other == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
